/* hw/phase_track_pkg.sv */
package phase_track_pkg;

  // Number of bins the phase store can hold
  localparam int BIN_COUNT = 256;

  // Cycles from the edge that issues a read address to the edge that shows its output
  localparam int PIPE_LATENCY = 4;

  // Target phase in whole steps of a 256-step turn
  typedef logic [7:0] target_t;

  // Stored phase with the integer part in the upper byte and the fraction in the lower
  typedef logic [15:0] phase_t;

  // Wrapped phase error or limited step
  typedef logic signed [15:0] phase_err_t;

  // Max step per frame in fraction units
  typedef logic [14:0] rate_t;

  // Bin index
  typedef logic [7:0] bin_addr_t;

  // Frame sequencer states
  typedef enum logic [1:0] {
    IDLE,
    PRIME,
    RUN,
    DRAIN
  } seq_state_t;

endpackage

/* hw/delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
  parameter int WIDTH  = 8,
  parameter int STAGES = 1
) (
  input  logic             CLK,
  input  logic             rst,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] pipe [STAGES];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < STAGES; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= din;
      for (int i = 1; i < STAGES; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  // Last register of the chain
  assign dout = pipe[STAGES-1];

endmodule

/* hw/phase_memory.sv */
`timescale 1ns/1ps

module phase_memory
  import phase_track_pkg::*;
(
  input  logic      CLK,
  input  bin_addr_t rd_addr,
  output phase_t    rd_data,
  input  logic      wr_en,
  input  bin_addr_t wr_addr,
  input  phase_t    wr_data
);

  // All bins start at phase zero
  phase_t mem [BIN_COUNT] = '{default: '0};

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read with the data one cycle after the address
  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];
  end

  // The sequencer spaces reads and write-backs so a bin is never read while it is written
  a_no_rw_collision : assert property (
    @(posedge CLK) wr_en |-> (wr_addr != rd_addr)
  ) else $error("phase_memory: write to bin %0d collides with read", wr_addr);

endmodule

/* hw/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer
  import phase_track_pkg::*;
#(
  parameter int DEPTH = 249
) (
  input  logic      CLK,
  input  logic      rst,
  input  logic      start,
  input  rate_t     max_step,
  output bin_addr_t rd_addr,
  output logic      rd_valid,
  output rate_t     rate,
  output logic      busy
);

  seq_state_t state;
  logic [8:0] tick;
  logic       addr_valid;

  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= IDLE;
      tick    <= '0;
      rd_addr <= '0;
      rate    <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state   <= PRIME;
            tick    <= '0;
            rd_addr <= '0;
            rate    <= max_step;
          end
        end
        PRIME: begin
          state <= RUN;
        end
        RUN: begin
          if (int'(tick) == DEPTH) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (int'(tick) == DEPTH + PIPE_LATENCY) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase

      // Address keeps walking through drain so it stays clear of the write-backs
      if (state != IDLE) begin
        tick    <= tick + 9'd1;
        rd_addr <= (int'(rd_addr) == DEPTH - 1) ? '0 : rd_addr + 8'd1;
      end
    end
  end

  assign addr_valid = (state == PRIME) || (state == RUN && int'(tick) < DEPTH);
  assign busy = (state != IDLE);

  // Valid follows the registered read of the memory
  delay_line #(
    .WIDTH (1),
    .STAGES(1)
  ) u_valid_dly (
    .CLK (CLK),
    .rst (rst),
    .din (addr_valid),
    .dout(rd_valid)
  );

  a_addr_in_range : assert property (
    @(posedge CLK) disable iff (rst) int'(rd_addr) < DEPTH
  ) else $error("frame_sequencer: bin address %0d out of range", rd_addr);

endmodule

/* hw/phase_error_stage.sv */
`timescale 1ns/1ps

module phase_error_stage
  import phase_track_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic       valid_in,
  input  target_t    target,
  input  phase_t     current,
  output phase_err_t err,
  output logic       valid_out
);

  phase_t diff;

  // Difference modulo one turn; read as signed it is the short way round
  assign diff = {target, 8'h00} - current;

  always_ff @(posedge CLK) begin
    err <= phase_err_t'(diff);
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

endmodule

/* hw/slew_limit_stage.sv */
`timescale 1ns/1ps

module slew_limit_stage
  import phase_track_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic       valid_in,
  input  phase_err_t err,
  input  rate_t      rate,
  output phase_err_t step,
  output logic       valid_out
);

  logic signed [16:0] err_x;
  logic signed [16:0] lim_p;
  logic signed [16:0] lim_n;
  logic signed [16:0] step_x;
  logic        [16:0] step_mag;

  // One extra bit so the negated limit never overflows
  assign err_x = {err[15], err};
  assign lim_p = {2'b00, rate};
  assign lim_n = -lim_p;

  always_ff @(posedge CLK) begin
    if (err_x > lim_p) begin
      step <= lim_p[15:0];
    end else if (err_x < lim_n) begin
      step <= lim_n[15:0];
    end else begin
      step <= err;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  assign step_x   = {step[15], step};
  assign step_mag = step[15] ? 17'(-step_x) : 17'(step_x);

  // Rate only changes between frames, so it still holds the limit used for this step
  a_step_limited : assert property (
    @(posedge CLK) disable iff (rst) valid_out |-> (step_mag <= {2'b00, rate})
  ) else $error("slew_limit_stage: step %0d exceeds rate %0d", step, rate);

endmodule

/* hw/phase_accum_stage.sv */
`timescale 1ns/1ps

module phase_accum_stage
  import phase_track_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic       valid_in,
  input  phase_t     current,
  input  phase_err_t step,
  output phase_t     next_phase,
  output logic       valid_out
);

  // Sum wraps at one full turn
  always_ff @(posedge CLK) begin
    next_phase <= current + phase_t'(step);
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

endmodule

/* hw/phase_tracker_top.sv */
`timescale 1ns/1ps

module phase_tracker_top
  import phase_track_pkg::*;
#(
  parameter int DEPTH = 249
) (
  input  logic    CLK,
  input  logic    rst,
  input  logic    start,
  input  target_t target,
  input  rate_t   max_step,
  output target_t phase_out,
  output logic    out_valid
);

  bin_addr_t  rd_addr;
  bin_addr_t  wr_addr;
  logic       rd_valid;
  rate_t      rate;
  logic       busy;
  phase_t     rd_data;
  phase_t     current_d;
  target_t    target_d;
  phase_err_t err;
  logic       err_valid;
  phase_err_t step;
  logic       step_valid;
  phase_t     next_phase;
  logic       sum_valid;

  frame_sequencer #(
    .DEPTH(DEPTH)
  ) u_seq (
    .CLK     (CLK),
    .rst     (rst),
    .start   (start),
    .max_step(max_step),
    .rd_addr (rd_addr),
    .rd_valid(rd_valid),
    .rate    (rate),
    .busy    (busy)
  );

  phase_memory u_mem (
    .CLK    (CLK),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .wr_en  (sum_valid),
    .wr_addr(wr_addr),
    .wr_data(next_phase)
  );

  // Target lines up with the memory read data
  delay_line #(
    .WIDTH ($bits(target_t)),
    .STAGES(1)
  ) u_target_dly (
    .CLK (CLK),
    .rst (rst),
    .din (target),
    .dout(target_d)
  );

  // Stored phase skips the error and slew stages
  delay_line #(
    .WIDTH ($bits(phase_t)),
    .STAGES(PIPE_LATENCY - 2)
  ) u_phase_dly (
    .CLK (CLK),
    .rst (rst),
    .din (rd_data),
    .dout(current_d)
  );

  // Read address follows the bin to the write-back
  delay_line #(
    .WIDTH ($bits(bin_addr_t)),
    .STAGES(PIPE_LATENCY)
  ) u_addr_dly (
    .CLK (CLK),
    .rst (rst),
    .din (rd_addr),
    .dout(wr_addr)
  );

  phase_error_stage u_err (
    .CLK      (CLK),
    .rst      (rst),
    .valid_in (rd_valid),
    .target   (target_d),
    .current  (rd_data),
    .err      (err),
    .valid_out(err_valid)
  );

  slew_limit_stage u_slew (
    .CLK      (CLK),
    .rst      (rst),
    .valid_in (err_valid),
    .err      (err),
    .rate     (rate),
    .step     (step),
    .valid_out(step_valid)
  );

  phase_accum_stage u_accum (
    .CLK       (CLK),
    .rst       (rst),
    .valid_in  (step_valid),
    .current   (current_d),
    .step      (step),
    .next_phase(next_phase),
    .valid_out (sum_valid)
  );

  assign phase_out = next_phase[15:8];
  assign out_valid = sum_valid;

  // No output may appear once the frame and its drain are over
  a_valid_in_frame : assert property (
    @(posedge CLK) disable iff (rst) out_valid |-> busy
  ) else $error("phase_tracker_top: output valid outside a frame");

endmodule

/* tests/tb_phase_tracker_tasks.svh */
`ifndef TB_PHASE_TRACKER_TASKS_SVH
`define TB_PHASE_TRACKER_TASKS_SVH

task automatic compare_phase(input target_t got, input target_t expected, input string what);
  if (got !== expected) begin
    fail_now($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                       $time, what, got, expected));
  end
endtask

task automatic compare_count(input int got, input int expected, input string what);
  if (got != expected) begin
    fail_now($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                       $time, what, got, expected));
  end
endtask

// Starts a frame, drives one target per edge and waits for all outputs
task automatic run_frame(input rate_t lim, input bit exact, input bit extra_start);
  phase_t nxt;
  int     waited;
  repeat (2) @(posedge CLK);
  #1;
  start    = 1'b1;
  max_step = lim;
  @(posedge CLK);
  #1;
  start_cyc = cyc;
  for (int k = 0; k < DEPTH; k++) begin
    nxt      = model_step(model[k], frame_tgt[k], lim);
    model[k] = nxt;
    exp_q.push_back(exact ? frame_tgt[k] : nxt[15:8]);
    bin_q.push_back(bin_addr_t'(k));
    target = frame_tgt[k];
    // A start with another limit in mid frame must change nothing
    start    = extra_start && (k == DEPTH / 2);
    max_step = start ? ~lim : lim;
    @(posedge CLK);
    #1;
  end
  start    = extra_start;
  max_step = lim;
  @(posedge CLK);
  #1;
  start  = 1'b0;
  waited = 0;
  while (exp_q.size() != 0) begin
    @(posedge CLK);
    waited++;
    if (waited > DEPTH + 2 * PIPE_LATENCY) begin
      fail_now("The outputs of a frame did not all arrive");
    end
  end
endtask

task automatic random_targets();
  for (int k = 0; k < BIN_COUNT; k++) begin
    frame_tgt[k] = target_t'($urandom);
  end
endtask

task automatic idle_then_single_frame();
  repeat (10) begin
    @(posedge CLK);
    #1;
    if (out_valid !== 1'b0) begin
      fail_now("out_valid went high before any start was given");
    end
  end
  random_targets();
  run_frame(rate_t'(1000), 1'b0, 1'b0);
endtask

// Largest limit reaches every target within the frame
task automatic full_slew_frame();
  random_targets();
  run_frame(15'h7fff, 1'b1, 1'b0);
endtask

task automatic limited_slew_frames();
  for (int k = 0; k < BIN_COUNT; k++) begin
    frame_tgt[k] = model[k][15:8] + target_t'($urandom % 41) - 8'd20;
  end
  repeat (6) begin
    run_frame(rate_t'(300), 1'b0, 1'b0);
  end
endtask

// Bin 0 goes from 5 toward 250 by two whole steps a frame down through zero
task automatic wrap_through_zero();
  for (int k = 0; k < BIN_COUNT; k++) begin
    frame_tgt[k] = model[k][15:8];
  end
  frame_tgt[0] = 8'd5;
  repeat (2) begin
    run_frame(15'h7fff, 1'b1, 1'b0);
  end
  frame_tgt[0] = 8'd250;
  for (int i = 1; i <= 4; i++) begin
    run_frame(rate_t'(512), 1'b0, 1'b0);
    compare_phase(last_out[0], target_t'(5 - 2 * i), "bin 0 on its way through zero");
  end
endtask

task automatic start_while_busy();
  random_targets();
  run_frame(rate_t'(2000), 1'b0, 1'b1);
endtask

task automatic random_frames();
  rate_t lim;
  repeat (50) begin
    random_targets();
    if ($urandom % 2 == 0) begin
      lim = rate_t'($urandom);
    end else begin
      lim = rate_t'($urandom % 1024);
    end
    run_frame(lim, 1'b0, 1'b0);
  end
endtask

`endif

/* tests/tb_phase_tracker.sv */
`timescale 1ns/1ps

module tb_phase_tracker
  import phase_track_pkg::*;
();

  localparam int DEPTH      = 20;
  localparam int NUM_FRAMES = 65;

  logic    CLK;
  logic    rst;
  logic    start;
  target_t target;
  rate_t   max_step;
  target_t phase_out;
  logic    out_valid;

  // Reference phase, next frame target and last seen output per bin
  phase_t    model [BIN_COUNT];
  target_t   frame_tgt [BIN_COUNT];
  target_t   last_out [BIN_COUNT];
  target_t   exp_q [$];
  bin_addr_t bin_q [$];
  int        cyc = 0;
  int        start_cyc = 0;
  int        run_len = 0;
  logic      prev_valid = 1'b0;

  phase_tracker_top #(
    .DEPTH(DEPTH)
  ) dut (
    .CLK      (CLK),
    .rst      (rst),
    .start    (start),
    .target   (target),
    .max_step (max_step),
    .phase_out(phase_out),
    .out_valid(out_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failed check");
  endtask

  // Error taken the short way round is clamped and then added modulo one turn
  function automatic phase_t model_step(phase_t cur, target_t tgt, rate_t lim);
    int err;
    int step;
    err  = (int'(tgt) * 256 - int'(cur) + 98304) % 65536 - 32768;
    step = (err > int'(lim)) ? int'(lim) : ((err < -int'(lim)) ? -int'(lim) : err);
    return phase_t'((int'(cur) + step + 65536) % 65536);
  endfunction

  // Output checker sampled mid-cycle
  always @(negedge CLK) begin : monitor
    target_t   exp_val;
    bin_addr_t exp_bin;
    if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        fail_now($sformatf("At %0t ns out_valid is high with no output expected", $time));
      end
      exp_val = exp_q.pop_front();
      exp_bin = bin_q.pop_front();
      // First output shows PIPE_LATENCY edges after the start edge
      if (!prev_valid) begin
        compare_count(cyc - start_cyc, PIPE_LATENCY, "edges from start to first output");
      end
      compare_phase(phase_out, exp_val, $sformatf("phase_out of bin %0d", exp_bin));
      last_out[exp_bin] = phase_out;
      run_len++;
    end else if (!rst && prev_valid) begin
      compare_count(run_len, DEPTH, "out_valid cycles in one frame");
      run_len = 0;
    end
    prev_valid = out_valid && !rst;
  end

  initial begin
    repeat (NUM_FRAMES * (DEPTH + 10) + 200) @(posedge CLK);
    fail_now("Watchdog expired before the test sequence finished");
  end

  initial begin
    void'($urandom(99455));
    rst      = 1'b1;
    start    = 1'b0;
    target   = '0;
    max_step = '0;
    for (int i = 0; i < BIN_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (8) @(posedge CLK);
    #1;
    rst = 1'b0;
    idle_then_single_frame();
    full_slew_frame();
    limited_slew_frames();
    wrap_through_zero();
    start_while_busy();
    random_frames();
    repeat (PIPE_LATENCY) @(posedge CLK);
    if (exp_q.size() == 0 && run_len == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_now("Some expected outputs never appeared");
    end
  end

  `include "tb_phase_tracker_tasks.svh"

endmodule

/* verilog.f */
+incdir+tests
hw/phase_track_pkg.sv
hw/delay_line.sv
hw/phase_memory.sv
hw/frame_sequencer.sv
hw/phase_error_stage.sv
hw/slew_limit_stage.sv
hw/phase_accum_stage.sv
hw/phase_tracker_top.sv
tests/tb_phase_tracker.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the phase tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_phase_tracker
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module "$TOP" -o "$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

echo "Simulation passed"
exit 0
